// File: build.f
+incdir+src
src/radio_pkg.sv
src/axis_pipe_reg.sv
src/chdr_demux.sv
src/radio_ctrl_proc.sv
src/radio_settings.sv
src/timekeeper.sv
src/radio_top.sv
testbench/tb_radio.sv

// File: run_sim.sh
#!/bin/sh
# Builds the radio testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_radio -f build.f || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_radio)"
echo "$out"
echo "$out" | grep -qx "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/tb_radio.sv
// Self-checking testbench for radio_top, sends CHDR commands and data and checks every response
`timescale 1ns/100ps
`include "radio_macros.svh"

module tb_radio
   import radio_pkg::*;
();

   localparam logic [31:0] RADIO_NUM  = 32'h0000_0003;
   localparam int          TIMEOUT    = 1000;
   localparam logic [63:0] TIME_BOUND = 64'd1000;

   logic        radio_clk;
   logic        i_rst_n;
   logic [63:0] i_in_tdata;
   logic        i_in_tlast;
   logic        i_in_tvalid;
   logic        o_in_tready;
   logic [63:0] o_out_tdata;
   logic        o_out_tlast;
   logic        o_out_tvalid;
   logic        i_out_tready;
   sample_t     i_rx;
   sample_t     o_tx;
   logic        i_pps;
   logic        o_sync_dacs;
   logic [7:0]  o_misc_outs;

   integer seed          = 32'hcc4c_ff8e;
   int     assert_errors = 0;
   int     check_errors  = 0;
   int     tests_done    = 0;
   int     beats_seen    = 0;
   int     sync_pulses   = 0;
   int     sync_writes   = 0;

   // Expected response beats, payloads as a lo..hi window
   logic [63:0] exp_lo   [0:127];
   logic [63:0] exp_hi   [0:127];
   logic        exp_last [0:127];
   logic [6:0]  wr_idx = 7'd0;
   logic [6:0]  rd_idx = 7'd0;
   logic [63:0] last_payload;
   sample_t     tx_mem [0:15];
   logic [3:0]  tx_wr    = 4'd0;
   logic [3:0]  tx_rd    = 4'd0;
   logic        tx_chk   = 1'b0;
   logic        idle_chk = 1'b0;
   logic        beat_fire;
   logic        pending;

   // Model of the setting registers
   logic [11:0] seq_cnt   = 12'h3a0;
   rb_sel_t     m_sel     = 3'd0;
   logic        m_loop    = 1'b0;
   set_data_t   m_test    = 32'd0;
   sample_t     m_idle    = 32'd0;
   set_data_t   m_time_hi = 32'd0;
   logic [63:0] t_min     = 64'd0;
   logic [63:0] t_max     = 64'd0;
   logic [63:0] pps_min   = 64'd0;
   logic [63:0] pps_max   = 64'd0;

   radio_top #(.RADIO_NUM(RADIO_NUM)) dut (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_in_tdata(i_in_tdata), .i_in_tlast(i_in_tlast),
      .i_in_tvalid(i_in_tvalid), .o_in_tready(o_in_tready),
      .o_out_tdata(o_out_tdata), .o_out_tlast(o_out_tlast),
      .o_out_tvalid(o_out_tvalid), .i_out_tready(i_out_tready),
      .i_rx(i_rx), .o_tx(o_tx), .i_pps(i_pps),
      .o_sync_dacs(o_sync_dacs), .o_misc_outs(o_misc_outs));

   initial begin
      radio_clk = 1'b0;
      forever #4 radio_clk = ~radio_clk;
   end

   ////////////////////////////////////////
   // Response and output checks
   ////////////////////////////////////////
   assign beat_fire = o_out_tvalid && i_out_tready;
   assign pending   = (rd_idx != wr_idx);

   always @(posedge radio_clk) begin
      if (beat_fire && pending) begin
         rd_idx       <= rd_idx + 7'd1;
         last_payload <= o_out_tdata;
         beats_seen   <= beats_seen + 1;
      end
      if (tx_chk && o_tx != m_idle && tx_rd != tx_wr) begin
         tx_rd <= tx_rd + 4'd1;
      end
      if (i_rst_n && o_sync_dacs) begin
         sync_pulses <= sync_pulses + 1;
      end
   end

   a_resp_pending: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      beat_fire |-> pending)
      else begin
         $display("response beat %h arrived with no command outstanding", o_out_tdata);
         assert_errors++;
      end

   a_resp_data: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      beat_fire && pending |-> o_out_tdata >= exp_lo[rd_idx] && o_out_tdata <= exp_hi[rd_idx])
      else begin
         $display("mismatch o_out_tdata got %h exp %h to %h",
                  o_out_tdata, exp_lo[rd_idx], exp_hi[rd_idx]);
         assert_errors++;
      end

   a_resp_last: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      beat_fire && pending |-> o_out_tlast == exp_last[rd_idx])
      else begin
         $display("mismatch o_out_tlast got %h exp %h", o_out_tlast, exp_last[rd_idx]);
         assert_errors++;
      end

   a_tx_idle: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      idle_chk |-> o_tx == m_idle)
      else begin
         $display("mismatch o_tx got %h exp %h", o_tx, m_idle);
         assert_errors++;
      end

   // Non-idle DAC words must follow the sent samples in order
   a_tx_order: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      tx_chk && o_tx != m_idle |-> tx_rd != tx_wr && o_tx == tx_mem[tx_rd])
      else begin
         $display("mismatch o_tx got %h exp %h", o_tx, tx_mem[tx_rd]);
         assert_errors++;
      end

   a_sync_pulse: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_sync_dacs |=> !o_sync_dacs)
      else begin
         $display("o_sync_dacs stayed high for more than one cycle");
         assert_errors++;
      end

   ////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////
   task automatic drive_ready();
      forever begin
         @(posedge radio_clk);
         #1;
         i_out_tready = ($random(seed) % 4) != 0;
      end
   endtask

   task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got == exp) else begin
         $display("mismatch %s got %h exp %h", name, got, exp);
         check_errors++;
      end
   endtask

   function automatic logic [63:0] make_header(input logic [1:0] pkt_type,
                                               input logic [11:0] seq, input logic err);
      return {pkt_type, 49'd0, err, seq};
   endfunction

   task automatic push_expect(input logic [63:0] lo, input logic [63:0] hi, input logic last);
      exp_lo[wr_idx]   = lo;
      exp_hi[wr_idx]   = hi;
      exp_last[wr_idx] = last;
      wr_idx           = wr_idx + 7'd1;
   endtask

   // Ready is looked at mid-cycle, the beat moves on the next rising edge
   task automatic drive_beat(input logic [63:0] data, input logic last);
      int   n;
      logic accepted;
      n           = 0;
      accepted    = 1'b0;
      i_in_tdata  = data;
      i_in_tlast  = last;
      i_in_tvalid = 1'b1;
      while (!accepted && n < TIMEOUT) begin
         @(negedge radio_clk);
         accepted = o_in_tready;
         @(posedge radio_clk);
         #1;
         n++;
      end
      i_in_tvalid = 1'b0;
      if (!accepted) begin
         $display("input beat %h was never accepted", data);
         check_errors++;
      end
   endtask

   task automatic wait_responses();
      int n;
      n = 0;
      while (rd_idx != wr_idx && n < TIMEOUT) begin
         @(posedge radio_clk);
         #1;
         n++;
      end
      if (rd_idx != wr_idx) begin
         $display("response did not arrive within %0d cycles", TIMEOUT);
         check_errors++;
      end
   endtask

   task automatic wait_samples();
      int n;
      n = 0;
      while (tx_rd != tx_wr && n < TIMEOUT) begin
         @(posedge radio_clk);
         #1;
         n++;
      end
      if (tx_rd != tx_wr) begin
         $display("only %0d of %0d samples reached o_tx", tx_rd, tx_wr);
         check_errors++;
      end
   endtask

   task automatic apply_write(input set_addr_t addr, input set_data_t data);
      case (addr)
         `SR_LOOPBACK:   m_loop = data[0];
         `SR_TEST:       m_test = data;
         `SR_READBACK:   m_sel = data[2:0];
         `SR_CODEC_IDLE: m_idle = data;
         `SR_TIME_HI:    m_time_hi = data;
         `SR_DACSYNC:    sync_writes++;
         `SR_TIME_LO: begin
            t_min = {m_time_hi, data};
            t_max = t_min + TIME_BOUND;
         end
         default: ;
      endcase
   endtask

   task automatic expected_readback(output logic [63:0] lo, output logic [63:0] hi);
      case (m_sel)
         `RB_RX_TEST:   lo = {(m_loop ? m_idle : i_rx), m_test};
         `RB_TX_RX:     lo = {m_idle, i_rx};
         `RB_RADIO_NUM: lo = {32'd0, RADIO_NUM};
         default:       lo = 64'd0;
      endcase
      hi = lo;
      if (m_sel == `RB_TIME) begin
         lo = t_min;
         hi = t_max;
      end else if (m_sel == `RB_TIME_PPS) begin
         lo = pps_min;
         hi = pps_max;
      end
   endtask

   task automatic send_command(input set_addr_t addr, input set_data_t data);
      logic [63:0] lo;
      logic [63:0] hi;
      seq_cnt = seq_cnt + 12'd1;
      apply_write(addr, data);
      expected_readback(lo, hi);
      push_expect(make_header(2'd3, seq_cnt, 1'b0), make_header(2'd3, seq_cnt, 1'b0), 1'b0);
      push_expect(lo, hi, 1'b1);
      drive_beat(make_header(2'd2, seq_cnt, 1'b0), 1'b0);
      drive_beat({24'd0, addr, data}, 1'b1);
      wait_responses();
   endtask

   // Wrong length, no write, error flag and zero payload
   task automatic send_bad_command(input int beats, input set_addr_t addr, input set_data_t data);
      seq_cnt = seq_cnt + 12'd1;
      push_expect(make_header(2'd3, seq_cnt, 1'b1), make_header(2'd3, seq_cnt, 1'b1), 1'b0);
      push_expect(64'd0, 64'd0, 1'b1);
      drive_beat(make_header(2'd2, seq_cnt, 1'b0), beats == 1);
      for (int i = 1; i < beats; i++) begin
         drive_beat({24'd0, addr, data}, i == beats - 1);
      end
      wait_responses();
   endtask

   task automatic send_dropped(input logic [1:0] pkt_type);
      seq_cnt = seq_cnt + 12'd1;
      drive_beat(make_header(pkt_type, seq_cnt, 1'b0), 1'b0);
      drive_beat({$random(seed), $random(seed)}, 1'b1);
   endtask

   task automatic send_samples(input int count);
      sample_t smp;
      seq_cnt = seq_cnt + 12'd1;
      drive_beat(make_header(2'd0, seq_cnt, 1'b0), 1'b0);
      for (int i = 0; i < count; i++) begin
         smp = $random(seed);
         if (smp == m_idle)
            smp = ~smp;
         tx_mem[tx_wr] = smp;
         tx_wr         = tx_wr + 4'd1;
         drive_beat({$random(seed), smp}, i == count - 1);
      end
   endtask

   task automatic pulse_pps();
      i_pps = 1'b1;
      repeat (4) @(posedge radio_clk);
      #1;
      i_pps = 1'b0;
      repeat (4) @(posedge radio_clk);
      #1;
   endtask

   task automatic finish_test(input string name);
      tests_done++;
      $display("test %0d %s done, failures so far %0d",
               tests_done, name, assert_errors + check_errors);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial begin
      logic [63:0] t_before;
      logic [63:0] t_after;
      set_data_t   word;
      i_rst_n      = 1'b0;
      i_in_tdata   = 64'd0;
      i_in_tlast   = 1'b0;
      i_in_tvalid  = 1'b0;
      i_out_tready = 1'b0;
      i_pps        = 1'b0;
      i_rx         = $random(seed);
      fork
         drive_ready();
      join_none
      repeat (16) @(posedge radio_clk);
      #1;
      i_rst_n = 1'b1;
      check_equal("o_out_tvalid", {63'd0, o_out_tvalid}, 64'd0);
      check_equal("o_tx", {32'd0, o_tx}, 64'd0);
      check_equal("o_sync_dacs", {63'd0, o_sync_dacs}, 64'd0);
      check_equal("o_misc_outs", {56'd0, o_misc_outs}, 64'd0);

      send_command(`SR_READBACK, {29'd0, `RB_RX_TEST});
      send_command(`SR_TEST, $random(seed));
      send_command(`SR_READBACK, {29'd0, `RB_RADIO_NUM});
      finish_test("write_readback");

      send_command(`SR_CODEC_IDLE, $random(seed));
      idle_chk = 1'b1;
      send_command(`SR_LOOPBACK, 32'd1);
      send_command(`SR_READBACK, {29'd0, `RB_RX_TEST});
      send_command(`SR_READBACK, {29'd0, `RB_TX_RX});
      send_command(`SR_LOOPBACK, 32'd0);
      finish_test("loopback_idle");

      idle_chk = 1'b0;
      tx_chk   = 1'b1;
      send_samples(8);
      wait_samples();
      @(posedge radio_clk);
      #1;
      tx_chk   = 1'b0;
      idle_chk = 1'b1;
      finish_test("tx_data");

      // Keep the high half small so the window cannot wrap
      send_command(`SR_TIME_HI, $random(seed) & 32'h00ff_ffff);
      send_command(`SR_TIME_LO, $random(seed));
      send_command(`SR_READBACK, {29'd0, `RB_TIME});
      t_before = last_payload;
      pulse_pps();
      t_min = t_before + 64'd1;
      t_max = t_before + TIME_BOUND;
      send_command(`SR_READBACK, {29'd0, `RB_TIME});
      t_after = last_payload;
      pps_min = t_before;
      pps_max = t_after;
      send_command(`SR_READBACK, {29'd0, `RB_TIME_PPS});
      finish_test("timekeeper");

      send_command(`SR_READBACK, {29'd0, `RB_NONE});
      word = $random(seed);
      send_command(`SR_MISC_OUTS, word);
      check_equal("o_misc_outs", {56'd0, o_misc_outs}, {56'd0, word[7:0]});
      for (int i = 0; i < 3; i++) begin
         send_command(`SR_DACSYNC, $random(seed));
      end
      assert (sync_pulses == sync_writes) else begin
         $display("o_sync_dacs pulsed %0d times for %0d writes", sync_pulses, sync_writes);
         check_errors++;
      end
      finish_test("outputs");

      send_bad_command(1, `SR_TEST, 32'd0);
      send_bad_command(3, `SR_TEST, 32'hdead_beef);
      send_dropped(2'd1);
      send_dropped(2'd3);
      send_command(`SR_READBACK, {29'd0, `RB_RX_TEST});
      finish_test("robustness");

      $display("tests %0d, response beats %0d, assertion failures %0d, check failures %0d",
               tests_done, beats_seen, assert_errors, check_errors);
      if (assert_errors + check_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: src/radio_top.sv
// Radio control core top, one CHDR stream in and one response stream out on radio_clk
`timescale 1ns/100ps

module radio_top
   import radio_pkg::*;
#(
   parameter logic [31:0] RADIO_NUM = 32'd0
) (
   input  logic        radio_clk,
   input  logic        i_rst_n,

   input  logic [63:0] i_in_tdata,
   input  logic        i_in_tlast,
   input  logic        i_in_tvalid,
   output logic        o_in_tready,

   output logic [63:0] o_out_tdata,
   output logic        o_out_tlast,
   output logic        o_out_tvalid,
   input  logic        i_out_tready,

   input  sample_t     i_rx,
   output sample_t     o_tx,
   input  logic        i_pps,
   output logic        o_sync_dacs,
   output logic [7:0]  o_misc_outs
);

   logic [63:0] cmd_tdata;
   logic        cmd_tlast, cmd_tvalid, cmd_tready;
   chdr_beat_t  cmd_beat, ctrl_beat;
   logic        ctrl_valid, ctrl_ready;

   sample_t     smp_data, tx_smp_data;
   logic        smp_valid, smp_ready, tx_smp_valid, tx_smp_ready;

   logic [63:0] resp_tdata;
   logic        resp_tlast, resp_tvalid, resp_tready;
   chdr_beat_t  resp_beat, out_beat;

   logic        set_stb;
   set_addr_t   set_addr;
   set_data_t   set_data;
   logic [63:0] readback;
   vita_time_t  vita_time, vita_time_pps;

   ////////////////////////////////////////
   // Input split and command path
   ////////////////////////////////////////
   chdr_demux u_demux (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_in_tdata(i_in_tdata), .i_in_tlast(i_in_tlast),
      .i_in_tvalid(i_in_tvalid), .o_in_tready(o_in_tready),
      .o_cmd_tdata(cmd_tdata), .o_cmd_tlast(cmd_tlast),
      .o_cmd_tvalid(cmd_tvalid), .i_cmd_tready(cmd_tready),
      .o_smp_data(smp_data), .o_smp_valid(smp_valid), .i_smp_ready(smp_ready));

   assign cmd_beat = {cmd_tlast, cmd_tdata};

   axis_pipe_reg #(.payload_t(chdr_beat_t)) ctrl_pipe (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_data(cmd_beat), .i_valid(cmd_tvalid), .o_ready(cmd_tready),
      .o_data(ctrl_beat), .o_valid(ctrl_valid), .i_ready(ctrl_ready));

   radio_ctrl_proc u_ctrl_proc (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_cmd_tdata(ctrl_beat.data), .i_cmd_tlast(ctrl_beat.last),
      .i_cmd_tvalid(ctrl_valid), .o_cmd_tready(ctrl_ready),
      .o_set_stb(set_stb), .o_set_addr(set_addr), .o_set_data(set_data),
      .i_readback(readback),
      .o_resp_tdata(resp_tdata), .o_resp_tlast(resp_tlast),
      .o_resp_tvalid(resp_tvalid), .i_resp_tready(resp_tready));

   assign resp_beat = {resp_tlast, resp_tdata};

   axis_pipe_reg #(.payload_t(chdr_beat_t)) resp_pipe (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_data(resp_beat), .i_valid(resp_tvalid), .o_ready(resp_tready),
      .o_data(out_beat), .o_valid(o_out_tvalid), .i_ready(i_out_tready));

   assign o_out_tdata = out_beat.data;
   assign o_out_tlast = out_beat.last;

   ////////////////////////////////////////
   // TX samples, settings and time
   ////////////////////////////////////////
   axis_pipe_reg #(.payload_t(sample_t)) tx_pipe (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_data(smp_data), .i_valid(smp_valid), .o_ready(smp_ready),
      .o_data(tx_smp_data), .o_valid(tx_smp_valid), .i_ready(tx_smp_ready));

   radio_settings #(.RADIO_NUM(RADIO_NUM)) u_settings (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_time(vita_time), .i_time_pps(vita_time_pps), .i_rx(i_rx),
      .i_smp_data(tx_smp_data), .i_smp_valid(tx_smp_valid), .o_smp_ready(tx_smp_ready),
      .o_tx(o_tx), .o_readback(readback),
      .o_sync_dacs(o_sync_dacs), .o_misc_outs(o_misc_outs));

   timekeeper u_timekeeper (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_pps(i_pps), .o_time(vita_time), .o_time_pps(vita_time_pps));

endmodule

// File: src/timekeeper.sv
// VITA time counter, loadable over the setting bus, with a time latch on each PPS edge
`timescale 1ns/100ps
`include "radio_macros.svh"

module timekeeper
   import radio_pkg::*;
(
   input  logic       radio_clk,
   input  logic       i_rst_n,
   input  logic       i_set_stb,
   input  set_addr_t  i_set_addr,
   input  set_data_t  i_set_data,
   input  logic       i_pps,
   output vita_time_t o_time,
   output vita_time_t o_time_pps
);

   vita_time_t time_q;
   vita_time_t time_pps_q;
   set_data_t  time_hi_q;
   logic [1:0] pps_sync_q;
   logic       pps_del_q;
   logic       pps_edge;

   assign pps_edge = pps_sync_q[1] && !pps_del_q;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         time_q     <= '0;
         time_pps_q <= '0;
         time_hi_q  <= '0;
         pps_sync_q <= 2'b00;
         pps_del_q  <= 1'b0;
      end else begin
         pps_sync_q <= {pps_sync_q[0], i_pps};
         pps_del_q  <= pps_sync_q[1];
         if (i_set_stb && (i_set_addr == `SR_TIME_HI)) begin
            time_hi_q <= i_set_data;
         end
         // Low half write commits the whole time
         if (i_set_stb && (i_set_addr == `SR_TIME_LO)) begin
            time_q <= {time_hi_q, i_set_data};
         end else begin
            time_q <= time_q + 64'd1;
         end
         if (pps_edge) begin
            time_pps_q <= time_q;
         end
      end
   end

   assign o_time     = time_q;
   assign o_time_pps = time_pps_q;

endmodule

// File: src/radio_settings.sv
// Setting registers, readback mux and DAC word drive for the radio core
`timescale 1ns/100ps
`include "radio_macros.svh"

module radio_settings
   import radio_pkg::*;
#(
   parameter logic [31:0] RADIO_NUM = 32'd0
) (
   input  logic        radio_clk,
   input  logic        i_rst_n,

   input  logic        i_set_stb,
   input  set_addr_t   i_set_addr,
   input  set_data_t   i_set_data,

   input  vita_time_t  i_time,
   input  vita_time_t  i_time_pps,
   input  sample_t     i_rx,

   input  sample_t     i_smp_data,
   input  logic        i_smp_valid,
   output logic        o_smp_ready,

   output sample_t     o_tx,
   output logic [63:0] o_readback,
   output logic        o_sync_dacs,
   output logic [7:0]  o_misc_outs
);

   logic       sync_q;
   logic       loopback_q;
   set_data_t  test_q;
   logic [7:0] misc_q;
   rb_sel_t    rb_sel_q;
   sample_t    idle_q;
   sample_t    tx_q;
   sample_t    rx_fe;

   ////////////////////////////////////////
   // Setting bus decode
   ////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         sync_q     <= 1'b0;
         loopback_q <= 1'b0;
         test_q     <= '0;
         misc_q     <= 8'd0;
         rb_sel_q   <= '0;
         idle_q     <= '0;
      end else begin
         // Any write to the sync address fires one pulse
         sync_q <= i_set_stb && (i_set_addr == `SR_DACSYNC);
         if (i_set_stb) begin
            case (i_set_addr)
               `SR_LOOPBACK:   loopback_q <= i_set_data[0];
               `SR_TEST:       test_q     <= i_set_data;
               `SR_MISC_OUTS:  misc_q     <= i_set_data[7:0];
               `SR_READBACK:   rb_sel_q   <= i_set_data[2:0];
               `SR_CODEC_IDLE: idle_q     <= i_set_data;
               default: ;
            endcase
         end
      end
   end

   // TX word, idle when nothing arrives
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         tx_q <= '0;
      end else begin
         tx_q <= i_smp_valid ? i_smp_data : idle_q;
      end
   end

   assign o_smp_ready = 1'b1;
   assign rx_fe       = loopback_q ? tx_q : i_rx;

   always_comb begin
      case (rb_sel_q)
         `RB_NONE:      o_readback = 64'd0;
         `RB_TIME:      o_readback = i_time;
         `RB_TIME_PPS:  o_readback = i_time_pps;
         `RB_RX_TEST:   o_readback = {rx_fe, test_q};
         `RB_TX_RX:     o_readback = {tx_q, i_rx};
         `RB_RADIO_NUM: o_readback = {32'd0, RADIO_NUM};
         default:       o_readback = 64'd0;
      endcase
   end

   assign o_tx        = tx_q;
   assign o_sync_dacs = sync_q;
   assign o_misc_outs = misc_q;

endmodule

// File: src/radio_ctrl_proc.sv
// Command processor turning two-beat command packets into setting writes and responses
`timescale 1ns/100ps
`include "radio_macros.svh"

module radio_ctrl_proc
   import radio_pkg::*;
(
   input  logic        radio_clk,
   input  logic        i_rst_n,

   input  logic [63:0] i_cmd_tdata,
   input  logic        i_cmd_tlast,
   input  logic        i_cmd_tvalid,
   output logic        o_cmd_tready,

   output logic        o_set_stb,
   output set_addr_t   o_set_addr,
   output set_data_t   o_set_data,
   input  logic [63:0] i_readback,

   output logic [63:0] o_resp_tdata,
   output logic        o_resp_tlast,
   output logic        o_resp_tvalid,
   input  logic        i_resp_tready
);

   typedef enum logic [2:0] {
      S_HDR, S_PAYLOAD, S_DRAIN, S_STROBE, S_RESP_HDR, S_RESP_PAY
   } state_e;

   state_e                    state_q;
   logic [1:0]                beat_cnt_q;
   logic                      err_q;
   logic [`CHDR_SEQ_BITS-1:0] seq_q;
   set_addr_t                 addr_q;
   set_data_t                 data_q;
   logic [63:0]               rb_q;
   logic [63:0]               resp_hdr;
   logic                      cmd_fire;

   assign o_cmd_tready = (state_q == S_HDR) || (state_q == S_PAYLOAD) || (state_q == S_DRAIN);
   assign cmd_fire     = i_cmd_tvalid && o_cmd_tready;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         state_q    <= S_HDR;
         beat_cnt_q <= 2'd0;
         err_q      <= 1'b0;
      end else begin
         case (state_q)
            S_HDR, S_PAYLOAD, S_DRAIN: begin
               if (cmd_fire) begin
                  if (beat_cnt_q != 2'd3) begin
                     beat_cnt_q <= beat_cnt_q + 2'd1;
                  end
                  if (i_cmd_tlast) begin
                     // Only a second beat may close a good command
                     err_q      <= (beat_cnt_q != 2'd1);
                     beat_cnt_q <= 2'd0;
                     state_q    <= S_STROBE;
                  end else if (state_q == S_HDR) begin
                     state_q <= S_PAYLOAD;
                  end else begin
                     state_q <= S_DRAIN;
                  end
               end
            end
            S_STROBE:   state_q <= S_RESP_HDR;
            S_RESP_HDR: if (i_resp_tready) state_q <= S_RESP_PAY;
            S_RESP_PAY: if (i_resp_tready) state_q <= S_HDR;
            default:    state_q <= S_HDR;
         endcase
      end
   end

   ////////////////////////////////////////
   // Command fields and readback capture
   ////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (cmd_fire && (state_q == S_HDR)) begin
         seq_q <= i_cmd_tdata[`CHDR_SEQ_BITS-1:0];
      end
      if (cmd_fire && (state_q == S_PAYLOAD)) begin
         addr_q <= i_cmd_tdata[39:32];
         data_q <= i_cmd_tdata[31:0];
      end
      // Write has landed by now, last sample before header accept wins
      if (state_q == S_RESP_HDR) begin
         rb_q <= err_q ? 64'd0 : i_readback;
      end
   end

   assign o_set_stb  = (state_q == S_STROBE) && !err_q;
   assign o_set_addr = addr_q;
   assign o_set_data = data_q;

   always_comb begin
      resp_hdr                             = 64'd0;
      resp_hdr[`CHDR_TYPE_MSB -: 2]        = CHDR_RESPONSE;
      resp_hdr[`CHDR_ERR_BIT]              = err_q;
      resp_hdr[`CHDR_SEQ_BITS-1:0]         = seq_q;
   end

   assign o_resp_tdata  = (state_q == S_RESP_PAY) ? rb_q : resp_hdr;
   assign o_resp_tlast  = (state_q == S_RESP_PAY);
   assign o_resp_tvalid = (state_q == S_RESP_HDR) || (state_q == S_RESP_PAY);

   a_stb_single: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_set_stb |=> !o_set_stb);

endmodule

// File: src/chdr_demux.sv
// Splits the incoming CHDR stream into command packets and TX samples, draining the rest
`timescale 1ns/100ps
`include "radio_macros.svh"

module chdr_demux
   import radio_pkg::*;
(
   input  logic        radio_clk,
   input  logic        i_rst_n,

   input  logic [63:0] i_in_tdata,
   input  logic        i_in_tlast,
   input  logic        i_in_tvalid,
   output logic        o_in_tready,

   output logic [63:0] o_cmd_tdata,
   output logic        o_cmd_tlast,
   output logic        o_cmd_tvalid,
   input  logic        i_cmd_tready,

   output sample_t     o_smp_data,
   output logic        o_smp_valid,
   input  logic        i_smp_ready
);

   typedef enum logic [1:0] {ROUTE_DROP, ROUTE_CMD, ROUTE_SMP} route_e;

   route_e route_q;
   route_e hdr_route;
   route_e cur_route;
   logic   in_pkt_q;
   logic   in_fire;

   // Header beat decides the route
   always_comb begin
      case (chdr_type_e'(i_in_tdata[`CHDR_TYPE_MSB -: 2]))
         CHDR_COMMAND: hdr_route = ROUTE_CMD;
         CHDR_DATA:    hdr_route = ROUTE_SMP;
         default:      hdr_route = ROUTE_DROP;
      endcase
   end

   assign cur_route = in_pkt_q ? route_q : hdr_route;

   ////////////////////////////////////////
   // Output selection
   ////////////////////////////////////////
   assign o_cmd_tdata  = i_in_tdata;
   assign o_cmd_tlast  = i_in_tlast;
   assign o_cmd_tvalid = i_in_tvalid && (cur_route == ROUTE_CMD);

   // Data header is swallowed, payload beats become samples
   assign o_smp_data  = i_in_tdata[31:0];
   assign o_smp_valid = i_in_tvalid && in_pkt_q && (cur_route == ROUTE_SMP);

   always_comb begin
      case (cur_route)
         ROUTE_CMD: o_in_tready = i_cmd_tready;
         ROUTE_SMP: o_in_tready = in_pkt_q ? i_smp_ready : 1'b1;
         default:   o_in_tready = 1'b1;
      endcase
   end

   assign in_fire = i_in_tvalid && o_in_tready;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         in_pkt_q <= 1'b0;
         route_q  <= ROUTE_DROP;
      end else if (in_fire) begin
         in_pkt_q <= !i_in_tlast;
         if (!in_pkt_q) begin
            route_q <= hdr_route;
         end
      end
   end

   // Packet stays open on its route until the last beat moves
   a_route_held: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      in_pkt_q && !(in_fire && i_in_tlast) |=> in_pkt_q && $stable(route_q));

endmodule

// File: src/axis_pipe_reg.sv
// One-deep skid pipeline stage with registered ready, used on every stream link of the core
`timescale 1ns/100ps

module axis_pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     radio_clk,
   input  logic     i_rst_n,
   input  payload_t i_data,
   input  logic     i_valid,
   output logic     o_ready,
   output payload_t o_data,
   output logic     o_valid,
   input  logic     i_ready
);

   payload_t data_q;
   payload_t skid_q;
   logic     valid_q;
   logic     skid_valid_q;
   logic     in_fire;
   logic     load_main;

   assign in_fire   = i_valid && o_ready;
   // Main register may take a new beat when empty or draining
   assign load_main = !valid_q || i_ready;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         valid_q      <= 1'b0;
         skid_valid_q <= 1'b0;
      end else if (load_main) begin
         valid_q      <= skid_valid_q || in_fire;
         skid_valid_q <= 1'b0;
      end else if (in_fire) begin
         skid_valid_q <= 1'b1;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (load_main) begin
         data_q <= skid_valid_q ? skid_q : i_data;
      end else if (in_fire) begin
         skid_q <= i_data;
      end
   end

   assign o_ready = !skid_valid_q;
   assign o_valid = valid_q;
   assign o_data  = data_q;

   // Stalled output beat holds
   a_hold_stable: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

// File: src/radio_pkg.sv
// Shared types for the radio core, imported by each module that uses them
package radio_pkg;

   // Header bits 63:62
   typedef enum logic [1:0] {
      CHDR_DATA      = 2'd0,
      CHDR_FLOW_CTRL = 2'd1,
      CHDR_COMMAND   = 2'd2,
      CHDR_RESPONSE  = 2'd3
   } chdr_type_e;

   // One stream beat, last flag on top
   typedef struct packed {
      logic        last;
      logic [63:0] data;
   } chdr_beat_t;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // I in the high half, Q in the low half
   typedef logic [31:0] sample_t;

   typedef logic [63:0] vita_time_t;
   typedef logic [2:0]  rb_sel_t;

endpackage

// File: src/radio_macros.svh
// Setting addresses, readback selects and CHDR header fields, included by the radio RTL
`ifndef RADIO_MACROS_SVH
`define RADIO_MACROS_SVH

////////////////////////////////////////
// Setting bus addresses
////////////////////////////////////////
`define SR_DACSYNC     8'd5
`define SR_LOOPBACK    8'd6
`define SR_TEST        8'd7
`define SR_MISC_OUTS   8'd24
`define SR_READBACK    8'd32
`define SR_TIME_HI     8'd128
`define SR_TIME_LO     8'd129
`define SR_CODEC_IDLE  8'd250

// CHDR header fields
`define CHDR_TYPE_MSB  63
`define CHDR_SEQ_BITS  12
`define CHDR_ERR_BIT   12

// Readback mux selects
`define RB_NONE        3'd0
`define RB_TIME        3'd1
`define RB_TIME_PPS    3'd2
`define RB_RX_TEST     3'd3
`define RB_TX_RX       3'd5
`define RB_RADIO_NUM   3'd6

`endif
